// File: floors_fall.f
source/game_pkg.sv
source/floor_layout.sv
source/floor_slice.sv
source/floor_merge.sv
source/screen_fsm.sv
source/floors_fall.sv
test/tb_floors_fall.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; exit status is the simulation result
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_floors_fall -f floors_fall.f \
    -o sim_floors_fall \
    && ./obj_dir/sim_floors_fall \
    || { echo "Simulation did not pass"; exit 1; }

// File: source/floor_layout.sv
`timescale 1ns/100ps
`default_nettype none

module floor_layout (
    input  logic                                             pclk,
    input  logic                                             rst,
    input  game_pkg::video_t                                 video_in,
    input  game_pkg::obj_t                                   obj_in,
    input  game_pkg::coord_t                                 y_pos,
    output game_pkg::video_t                                 video_s1,
    output game_pkg::obj_t                                   obj_s1,
    output game_pkg::floor_t [game_pkg::NUM_FLOORS-1:0]      floors
);

    game_pkg::coord_t row_q  [game_pkg::NUM_FLOORS];
    game_pkg::coord_t hole_q [game_pkg::NUM_FLOORS];
    game_pkg::coord_t y_pos_q;
    game_pkg::coord_t y_pos_prev;
    logic             wrap;

    ////////////////////
    // Stage 1 registers

    always_ff @(posedge pclk) begin
        video_s1 <= video_in;
        obj_s1   <= obj_in;
        // Row k sits (k - 3) spacings away from y_pos, wrapping at 4096
        for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
            row_q[k] <= y_pos + game_pkg::coord_t'((k - 3) * int'(game_pkg::FLOOR_SPACING));
        end
    end

    ////////////////////
    // Scroll wrap and holes

    // Falling edge of y_pos through 1
    assign wrap = (y_pos_q <= 12'd1) && (y_pos_prev > 12'd1);

    always_ff @(posedge pclk) begin
        if (rst) begin
            y_pos_q    <= '0;
            y_pos_prev <= '0;
            for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
                hole_q[k] <= game_pkg::HOLE_INIT[k];
            end
        end else begin
            y_pos_q    <= y_pos;
            y_pos_prev <= y_pos_q;
            if (wrap) begin
                for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
                    // Sum stays below 2 * HOLE_SPAN, one subtraction is enough
                    if (hole_q[k] + game_pkg::HOLE_STEP[k] >= game_pkg::HOLE_SPAN) begin
                        hole_q[k] <= hole_q[k] + game_pkg::HOLE_STEP[k] - game_pkg::HOLE_SPAN;
                    end else begin
                        hole_q[k] <= hole_q[k] + game_pkg::HOLE_STEP[k];
                    end
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
            floors[k].row  = row_q[k];
            floors[k].hole = hole_q[k];
        end
    end

endmodule

`default_nettype wire

// File: source/floor_merge.sv
`timescale 1ns/100ps
`default_nettype none

module floor_merge (
    input  logic                                        pclk,
    input  logic                                        rst,
    input  game_pkg::video_t                            video_s1,
    input  game_pkg::obj_t                              obj_s1,
    input  game_pkg::slice_t [game_pkg::NUM_FLOORS-1:0] results,
    input  game_pkg::screen_e                           state,
    output game_pkg::video_t                            video_out,
    output logic                                        floor_hit,
    output game_pkg::coord_t                            y_obj_out
);

    logic [12:0]      hpos;
    logic [12:0]      vpos;
    logic [12:0]      obj_x;
    logic [12:0]      obj_y;
    logic             in_sprite;
    logic             on_floor;
    game_pkg::video_t pix_next;
    logic             hit_next;
    game_pkg::coord_t y_next;

    ////////////////////
    // Pixel overlay

    always_comb begin
        hpos  = 13'(video_s1.hcount);
        vpos  = 13'(video_s1.vcount);
        obj_x = 13'(obj_s1.x);
        obj_y = 13'(obj_s1.y);

        // Box is open at the top edge, closed at the bottom
        in_sprite = (hpos >= obj_x) && (hpos < obj_x + 13'(game_pkg::OBJECT_WIDTH)) &&
                    (vpos > obj_y) && (vpos <= obj_y + 13'(game_pkg::OBJECT_HEIGHT));

        on_floor = 1'b0;
        for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
            on_floor = on_floor | results[k].pix;
        end

        pix_next = video_s1;
        if (state == game_pkg::play) begin
            if (in_sprite) begin
                pix_next.rgb = game_pkg::OBJECT_COLOR;
            end else if (on_floor) begin
                pix_next.rgb = game_pkg::FLOOR_COLOR;
            end
        end
    end

    ////////////////////
    // Landing select

    always_comb begin
        hit_next = 1'b0;
        y_next   = y_obj_out;
        // Walk downwards so the lowest index is written last
        for (int k = game_pkg::NUM_FLOORS - 1; k >= 0; k--) begin
            if (results[k].land) begin
                hit_next = 1'b1;
                y_next   = results[k].land_y;
            end
        end
        if (!hit_next && (obj_s1.y == game_pkg::MAX_HEIGHT - game_pkg::OBJECT_HEIGHT)) begin
            hit_next = 1'b1;
            y_next   = obj_s1.y;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            video_out <= '0;
            floor_hit <= 1'b0;
            y_obj_out <= '0;
        end else begin
            video_out <= pix_next;
            floor_hit <= hit_next;
            y_obj_out <= y_next;
        end
    end

endmodule

`default_nettype wire

// File: source/floor_slice.sv
`timescale 1ns/100ps
`default_nettype none

module floor_slice (
    input  game_pkg::video_t video_s1,
    input  game_pkg::obj_t   obj_s1,
    input  game_pkg::floor_t flr,
    output game_pkg::slice_t result
);

    // Vertical compares run on 13 bits so row + height cannot wrap
    logic [12:0]      row_top;
    logic [12:0]      row_bot;
    logic [12:0]      vpos;
    logic [12:0]      foot;
    game_pkg::coord_t hpos;
    game_pkg::coord_t hole_end;
    logic             in_rows;
    logic             x_clear;

    always_comb begin
        row_top  = 13'(flr.row);
        row_bot  = row_top + 13'(game_pkg::FLOOR_HEIGHT);
        vpos     = 13'(video_s1.vcount);
        hpos     = game_pkg::coord_t'(video_s1.hcount);
        hole_end = flr.hole + game_pkg::HOLE;
        foot     = 13'(obj_s1.y) + 13'(game_pkg::OBJECT_HEIGHT);

        in_rows = (vpos >= row_top) && (vpos <= row_bot);

        // Sprite fits on the floor left of the hole or past its far edge
        x_clear = (obj_s1.x < flr.hole) ||
                  (obj_s1.x >= hole_end - game_pkg::OBJECT_WIDTH);

        result.pix = in_rows &&
                     (((hpos > 12'd0) && (hpos < flr.hole)) ||
                      ((hpos > hole_end) && (hpos < game_pkg::SCREEN_RIGHT)));
        result.land   = (foot >= row_top) && (foot <= row_bot) && x_clear;
        result.land_y = flr.row - game_pkg::OBJECT_HEIGHT - 12'd1;
    end

endmodule

`default_nettype wire

// File: source/floors_fall.sv
`timescale 1ns/100ps
`default_nettype none

module floors_fall (
    input  logic             pclk,
    input  logic             rst,
    input  logic             space_button,
    input  game_pkg::video_t video_in,
    input  game_pkg::coord_t x_obj,
    input  game_pkg::coord_t y_obj,
    input  game_pkg::coord_t y_pos,
    output game_pkg::video_t video_out,
    output logic             floor_hit,
    output logic             start,
    output logic             ending,
    output game_pkg::coord_t y_obj_out
);

    game_pkg::obj_t                              obj_in;
    game_pkg::video_t                            video_s1;
    game_pkg::obj_t                              obj_s1;
    game_pkg::floor_t [game_pkg::NUM_FLOORS-1:0] floors;
    game_pkg::slice_t [game_pkg::NUM_FLOORS-1:0] results;
    game_pkg::screen_e                           state;

    assign obj_in.x = x_obj;
    assign obj_in.y = y_obj;

    floor_layout i_layout (
        .pclk     (pclk),
        .rst      (rst),
        .video_in (video_in),
        .obj_in   (obj_in),
        .y_pos    (y_pos),
        .video_s1 (video_s1),
        .obj_s1   (obj_s1),
        .floors   (floors)
    );

    // One slice per floor
    for (genvar k = 0; k < game_pkg::NUM_FLOORS; k++) begin : g_slice
        floor_slice i_slice (
            .video_s1 (video_s1),
            .obj_s1   (obj_s1),
            .flr      (floors[k]),
            .result   (results[k])
        );
    end

    floor_merge i_merge (
        .pclk      (pclk),
        .rst       (rst),
        .video_s1  (video_s1),
        .obj_s1    (obj_s1),
        .results   (results),
        .state     (state),
        .video_out (video_out),
        .floor_hit (floor_hit),
        .y_obj_out (y_obj_out)
    );

    screen_fsm i_fsm (
        .pclk         (pclk),
        .rst          (rst),
        .space_button (space_button),
        .y_obj        (obj_s1.y),
        .state        (state),
        .start        (start),
        .ending       (ending)
    );

endmodule

`default_nettype wire

// File: source/game_pkg.sv
`default_nettype none

package game_pkg;

    ////////////////////
    // Basic types

    typedef logic [11:0] coord_t;

    // 4 bits per channel, red in the top nibble
    typedef logic [11:0] rgb_t;

    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        hblnk;
        logic        vsync;
        logic        vblnk;
        rgb_t        rgb;
    } video_t;

    // Sprite top-left corner
    typedef struct packed {
        coord_t x;
        coord_t y;
    } obj_t;

    typedef struct packed {
        coord_t row;
        coord_t hole;
    } floor_t;

    // Per-floor verdict for the current pixel and sprite position
    typedef struct packed {
        logic   pix;
        logic   land;
        coord_t land_y;
    } slice_t;

    typedef enum logic [1:0] {
        start_screen,
        play,
        game_over
    } screen_e;

    ////////////////////
    // Field geometry

    localparam int     NUM_FLOORS    = 7;
    localparam coord_t FLOOR_SPACING = 12'd150;
    localparam coord_t FLOOR_HEIGHT  = 12'd20;
    localparam coord_t HOLE          = 12'd60;
    localparam coord_t HOLE_SPAN     = 12'd740;
    localparam coord_t OBJECT_WIDTH  = 12'd36;
    localparam coord_t OBJECT_HEIGHT = 12'd48;
    localparam coord_t MAX_HEIGHT    = 12'd600;
    localparam coord_t SCREEN_RIGHT  = 12'd799;

    localparam rgb_t FLOOR_COLOR  = 12'h642;
    localparam rgb_t OBJECT_COLOR = 12'h81d;

    ////////////////////
    // Hole columns

    localparam coord_t HOLE_INIT [NUM_FLOORS] = '{
        12'd570, 12'd300, 12'd500, 12'd230, 12'd450, 12'd125, 12'd600
    };

    // Added on every scroll wrap, result taken modulo HOLE_SPAN
    localparam coord_t HOLE_STEP [NUM_FLOORS] = '{
        12'd50, 12'd250, 12'd640, 12'd660, 12'd50, 12'd250, 12'd640
    };

endpackage

`default_nettype wire

// File: source/screen_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module screen_fsm (
    input  logic              pclk,
    input  logic              rst,
    input  logic              space_button,
    input  game_pkg::coord_t  y_obj,
    output game_pkg::screen_e state,
    output logic              start,
    output logic              ending
);

    game_pkg::screen_e state_next;
    logic              space_q;

    // Space wins over the top-of-screen loss
    always_comb begin
        state_next = state;
        if (space_q) begin
            state_next = game_pkg::play;
        end else if (y_obj == 12'd1) begin
            state_next = game_pkg::game_over;
        end
    end

    always_ff @(posedge pclk) begin
        if (rst) begin
            space_q <= 1'b0;
            state   <= game_pkg::start_screen;
            start   <= 1'b1;
            ending  <= 1'b0;
        end else begin
            space_q <= space_button;
            state   <= state_next;
            start   <= (state == game_pkg::start_screen);
            ending  <= (state == game_pkg::game_over);
        end
    end

endmodule

`default_nettype wire

// File: test/tb_floors_fall.sv
`timescale 1ns/100ps
`default_nettype none

module tb_floors_fall;

    localparam int TIMEOUT    = 50;
    localparam int PLAY_Y_POS = 500;
    localparam int PARK_Y     = 1000;
    localparam int PASS_RGB   = 0;
    localparam int FLOOR_RGB  = 1;
    localparam int SPRITE_RGB = 2;

    logic              pclk;
    logic              rst;
    logic              space_button;
    game_pkg::video_t  video_in;
    game_pkg::coord_t  x_obj;
    game_pkg::coord_t  y_obj;
    game_pkg::coord_t  y_pos;
    game_pkg::video_t  video_out;
    logic              floor_hit;
    logic              start;
    logic              ending;
    game_pkg::coord_t  y_obj_out;
    logic [31:0]       rng;
    int                hole_m [game_pkg::NUM_FLOORS];

    floors_fall i_dut (
        .pclk         (pclk),
        .rst          (rst),
        .space_button (space_button),
        .video_in     (video_in),
        .x_obj        (x_obj),
        .y_obj        (y_obj),
        .y_pos        (y_pos),
        .video_out    (video_out),
        .floor_hit    (floor_hit),
        .start        (start),
        .ending       (ending),
        .y_obj_out    (y_obj_out)
    );

    initial begin
        pclk = 1'b0;
        forever #50 pclk = ~pclk;
    end

    ////////////////////
    // Helpers

    function automatic logic [31:0] next_random();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    // Row k sits (k - 3) spacings from the scroll position
    function automatic int row_of(int k, int ypos);
        return (ypos + (k - 3) * int'(game_pkg::FLOOR_SPACING)) & 4095;
    endfunction

    task automatic compare_values(string test_name, logic [63:0] expected, logic [63:0] actual);
        if (expected !== actual) begin
            $display("[FAIL] %s: expected %0h, actual %0h", test_name, expected, actual);
            $display("TESTBENCH FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic wait_for_flag(string flag_name, logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge pclk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("Timed out waiting for %s to become %0d", flag_name, level);
                $display("TESTBENCH FAILED");
                $fatal(1, "timeout");
            end
        end while (((flag_name == "start") ? start : ending) !== level);
    endtask

    task automatic set_scene(int x, int y, int ypos);
        @(posedge pclk);
        x_obj <= 12'(x);
        y_obj <= 12'(y);
        y_pos <= 12'(ypos);
    endtask

    task automatic pixel_check(string test_name, int h, int v, int kind);
        logic [31:0]      r1;
        logic [31:0]      r2;
        game_pkg::video_t vid;
        game_pkg::video_t expected;
        r1 = next_random();
        r2 = next_random();
        vid = {r1, r2[7:0]};
        vid.hcount = 11'(h);
        vid.vcount = 11'(v);
        expected = vid;
        if (kind == FLOOR_RGB) begin
            expected.rgb = game_pkg::FLOOR_COLOR;
        end else if (kind == SPRITE_RGB) begin
            expected.rgb = game_pkg::OBJECT_COLOR;
        end
        @(posedge pclk);
        video_in <= vid;
        repeat (2) @(posedge pclk);
        @(negedge pclk);
        compare_values(test_name, 64'(expected), 64'(video_out));
    endtask

    task automatic landing_check(string test_name, int x, int y, logic hit, int land_y);
        @(posedge pclk);
        x_obj <= 12'(x);
        y_obj <= 12'(y);
        repeat (2) @(posedge pclk);
        @(negedge pclk);
        compare_values({test_name, " hit"}, 64'(hit), 64'(floor_hit));
        compare_values({test_name, " y"}, 64'(land_y), 64'(y_obj_out));
    endtask

    // Random pixels must leave exactly 2 cycles later
    task automatic stream_passthrough(string test_name, int count);
        logic [31:0]      r1;
        logic [31:0]      r2;
        game_pkg::video_t vid;
        game_pkg::video_t old;
        game_pkg::video_t hist [$];
        for (int i = 0; i < count; i++) begin
            r1 = next_random();
            r2 = next_random();
            vid = {r1, r2[7:0]};
            @(posedge pclk);
            video_in <= vid;
            hist.push_back(vid);
            @(negedge pclk);
            if (hist.size() > 2) begin
                old = hist.pop_front();
                compare_values(test_name, 64'(old), 64'(video_out));
            end
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic reset_and_start_screen();
        @(negedge pclk);
        compare_values("reset start", 64'(1'b1), 64'(start));
        compare_values("reset ending", 64'(1'b0), 64'(ending));
        compare_values("reset floor_hit", 64'(1'b0), 64'(floor_hit));
        compare_values("reset video_out", 64'(0), 64'(video_out));
        stream_passthrough("start screen passthrough", 20);
        // A floor position must not be drawn on the start screen
        pixel_check("start screen floor", hole_m[1] - 10, row_of(1, PLAY_Y_POS) + 5, PASS_RGB);
    endtask

    task automatic enter_play_and_draw();
        int row;
        int hole;
        row  = row_of(1, PLAY_Y_POS);
        hole = hole_m[1];
        @(posedge pclk);
        space_button <= 1'b1;
        @(posedge pclk);
        space_button <= 1'b0;
        wait_for_flag("start", 1'b0);
        pixel_check("floor solid", hole - 10, row + 5, FLOOR_RGB);
        pixel_check("floor hole", hole + 10, row + 5, PASS_RGB);
        pixel_check("between floors", hole - 10, row + 75, PASS_RGB);
        pixel_check("floor bottom edge", hole - 10, row + 20, FLOOR_RGB);
    endtask

    task automatic sprite_priority();
        int row;
        row = row_of(1, PLAY_Y_POS);
        set_scene(100, row - 10, PLAY_Y_POS);
        pixel_check("sprite inside", 110, row + 5, SPRITE_RGB);
        pixel_check("right of sprite", 100 + int'(game_pkg::OBJECT_WIDTH), row + 5, FLOOR_RGB);
        pixel_check("left of sprite", 99, row + 5, FLOOR_RGB);
    endtask

    task automatic landing_cases();
        int row;
        int foot_y;
        row    = row_of(2, PLAY_Y_POS);
        foot_y = row + 5 - int'(game_pkg::OBJECT_HEIGHT);
        landing_check("landing on floor", 100, foot_y, 1'b1, row - 49);
        landing_check("landing over hole", hole_m[2] + 10, foot_y, 1'b0, row - 49);
        landing_check("bottom limit", 100, 552, 1'b1, 552);
    endtask

    task automatic hole_rotation();
        int row;
        int old_hole;
        row      = row_of(4, 1);
        old_hole = hole_m[4];
        set_scene(0, PARK_Y, 1);
        for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
            hole_m[k] = (hole_m[k] + int'(game_pkg::HOLE_STEP[k])) % int'(game_pkg::HOLE_SPAN);
        end
        repeat (4) @(posedge pclk);
        pixel_check("old hole column", old_hole + 10, row + 5, FLOOR_RGB);
        pixel_check("new hole column", hole_m[4] + 10, row + 5, PASS_RGB);
    endtask

    task automatic game_over_and_restart();
        set_scene(0, 1, 1);
        wait_for_flag("ending", 1'b1);
        compare_values("start in game over", 64'(1'b0), 64'(start));
        stream_passthrough("game over passthrough", 20);
        pixel_check("game over floor", hole_m[4] - 10, row_of(4, 1) + 5, PASS_RGB);
        @(posedge pclk);
        space_button <= 1'b1;
        y_obj        <= 12'(PARK_Y);
        wait_for_flag("ending", 1'b0);
        @(posedge pclk);
        space_button <= 1'b0;
        @(negedge pclk);
        compare_values("start after restart", 64'(1'b0), 64'(start));
        pixel_check("floor after restart", hole_m[4] - 10, row_of(4, 1) + 5, FLOOR_RGB);
    endtask

    initial begin
        rng          = 32'h5b6c_2d5c;
        rst          = 1'b1;
        space_button = 1'b0;
        video_in     = '0;
        x_obj        = '0;
        y_obj        = 12'(PARK_Y);
        y_pos        = 12'(PLAY_Y_POS);
        for (int k = 0; k < game_pkg::NUM_FLOORS; k++) begin
            hole_m[k] = int'(game_pkg::HOLE_INIT[k]);
        end
        repeat (8) @(posedge pclk);
        rst <= 1'b0;
        reset_and_start_screen();
        enter_play_and_draw();
        sprite_priority();
        landing_cases();
        hole_rotation();
        game_over_and_restart();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire
